/* Bender.yml */
package:
  name: dbg_chain

sources:
  - logic/dbg_pkg.sv
  - logic/dbg_req_fifo.sv
  - logic/dbg_bus_master.sv
  - logic/dbg_bus_module.sv
  - logic/dbg_ctrl_module.sv
  - logic/dbg_chain_select.sv
  - logic/dbg_top.sv
  - target: test
    files:
      - tb/dbg_tb.sv

/* dbg_chain.f */
logic/dbg_pkg.sv
logic/dbg_req_fifo.sv
logic/dbg_bus_master.sv
logic/dbg_bus_module.sv
logic/dbg_ctrl_module.sv
logic/dbg_chain_select.sv
logic/dbg_top.sv
tb/dbg_tb.sv

/* logic/dbg_bus_master.sv */
`timescale 1ns/1ps

module dbg_bus_master (
  input  logic              tck_i,
  input  logic              tlr_i,
  // FIFO side
  input  logic              not_empty_i,
  input  dbg_pkg::bus_req_t head_i,
  output logic              pop_o,
  output logic              busy_o,
  // External bus
  output dbg_pkg::bus_req_t bus_req_o,
  output logic              bus_valid_o,
  input  logic              bus_ready_i,
  input  dbg_pkg::data_t    bus_rdata_i,
  // Read response to bus module
  output logic              rsp_valid_o,
  output dbg_pkg::data_t    rsp_data_o
);

  import dbg_pkg::*;

  mst_state_e state_q;
  bus_req_t   req_q;
  logic       rsp_valid_q;
  data_t      rsp_data_q;

  // Pop as we leave idle
  assign pop_o = (state_q == ST_IDLE) && not_empty_i;

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      state_q     <= ST_IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (not_empty_i) begin
            state_q <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          // Ready edge completes the access
          if (bus_ready_i) begin
            state_q     <= ST_IDLE;
            rsp_valid_q <= !req_q.write;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request held stable for the whole access
  always_ff @(posedge tck_i) begin
    if (pop_o) begin
      req_q <= head_i;
    end
  end

  // Read word sampled at the completing edge
  always_ff @(posedge tck_i) begin
    if (state_q == ST_ACCESS && bus_ready_i) begin
      rsp_data_q <= bus_rdata_i;
    end
  end

  assign busy_o      = (state_q == ST_ACCESS);
  assign bus_valid_o = (state_q == ST_ACCESS);
  assign bus_req_o   = req_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;

endmodule

/* logic/dbg_bus_module.sv */
`timescale 1ns/1ps

module dbg_bus_module (
  input  logic                       tck_i,
  input  logic                       tlr_i,
  input  logic                       tdi_i,
  input  logic                       shift_dr_i,
  input  logic                       capture_dr_i,
  input  logic                       update_dr_i,
  input  logic [dbg_pkg::DR_LEN-1:0] data_reg_i,
  input  logic                       sel_i,
  output logic                       tdo_o,
  output logic                       inhibit_o,
  // Request strobe into FIFO
  output logic                       push_o,
  output dbg_pkg::bus_req_t          push_req_o,
  // Pending work indicators
  input  logic                       fifo_not_empty_i,
  input  logic                       master_busy_i,
  // Read response from master
  input  logic                       rsp_valid_i,
  input  dbg_pkg::data_t             rsp_data_i
);

  import dbg_pkg::*;

  // rd_valid plus read word
  localparam int CAP_W = $bits(data_t) + 1;

  bus_op_e          op;
  logic             cmd_upd;
  logic             push_q;
  bus_req_t         req_q;
  data_t            rdata_q;
  logic             rd_valid_q;
  logic [CAP_W-1:0] cap_q;

  // Opcode of a bus command
  assign op = bus_op_e'(data_reg_i[DR_OP_MSB -: 2]);
  // Update-DR for this module, not a select
  assign cmd_upd = update_dr_i && sel_i && !data_reg_i[DR_SEL_BIT];

  ////////////////////////////////////////
  // Command decode and push
  ////////////////////////////////////////

  // Strobe one cycle after Update-DR
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      push_q <= 1'b0;
    end else begin
      push_q <= cmd_upd && (op == OP_WRITE || op == OP_READ);
    end
  end

  // Request payload
  always_ff @(posedge tck_i) begin
    if (cmd_upd) begin
      req_q.write <= (op == OP_WRITE);
      req_q.addr  <= data_reg_i[DR_ADDR_MSB -: $bits(addr_t)];
      req_q.data  <= data_reg_i[DR_WDATA_MSB -: $bits(data_t)];
    end
  end

  assign push_o     = push_q;
  assign push_req_o = req_q;

  // Request in flight anywhere in the path
  assign inhibit_o = push_q | fifo_not_empty_i | master_busy_i;

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  // Sticky valid, new read clears it
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      rd_valid_q <= 1'b0;
    end else if (cmd_upd && op == OP_READ) begin
      rd_valid_q <= 1'b0;
    end else if (rsp_valid_i) begin
      rd_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge tck_i) begin
    if (rsp_valid_i) begin
      rdata_q <= rsp_data_i;
    end
  end

  // Capture then shift out LSB first
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      cap_q <= '0;
    end else if (capture_dr_i && sel_i) begin
      cap_q <= {rdata_q, rd_valid_q};
    end else if (shift_dr_i && sel_i) begin
      cap_q <= {tdi_i, cap_q[CAP_W-1:1]};
    end
  end

  assign tdo_o = cap_q[0];

endmodule

/* logic/dbg_chain_select.sv */
`timescale 1ns/1ps

module dbg_chain_select (
  input  logic                     tck_i,
  input  logic                     tlr_i,
  input  logic                     tdi_i,
  input  logic                     shift_dr_i,
  input  logic                     update_dr_i,
  input  logic                     debug_select_i,
  // Whole main register, seen by every module
  output logic [dbg_pkg::DR_LEN-1:0] data_reg_o,
  // One-hot module selects
  output logic                     bus_sel_o,
  output logic                     ctrl_sel_o,
  // Module returns
  input  logic                     bus_inhibit_i,
  input  logic                     bus_tdo_i,
  input  logic                     ctrl_tdo_i,
  output logic                     tdo_o
);

  import dbg_pkg::*;

  logic [DR_LEN-1:0] shift_q;
  dbg_module_e       mod_id_q;
  logic              select_cmd;
  dbg_module_e       mod_id_in;

  // Fields of a select command
  assign select_cmd = shift_q[DR_SEL_BIT];
  assign mod_id_in  = dbg_module_e'(shift_q[DR_ID_MSB -: 2]);

  ////////////////////////////////////////
  // Main shift register
  ////////////////////////////////////////

  // TDI enters at the top, LSB falls off
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      shift_q <= '0;
    end else if (debug_select_i && shift_dr_i) begin
      shift_q <= {tdi_i, shift_q[DR_LEN-1:1]};
    end
  end

  assign data_reg_o = shift_q;

  ////////////////////////////////////////
  // Module ID
  ////////////////////////////////////////

  // New ID only when no bus work is pending
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      mod_id_q <= MOD_BUS;
    end else if (debug_select_i && update_dr_i && select_cmd && !bus_inhibit_i) begin
      mod_id_q <= mod_id_in;
    end
  end

  // Select decode
  assign bus_sel_o  = (mod_id_q == MOD_BUS);
  assign ctrl_sel_o = (mod_id_q == MOD_CTRL);

  // TDO mux, reserved IDs read as 0
  always_comb begin
    case (mod_id_q)
      MOD_BUS:  tdo_o = bus_tdo_i;
      MOD_CTRL: tdo_o = ctrl_tdo_i;
      default:  tdo_o = 1'b0;
    endcase
  end

endmodule

/* logic/dbg_ctrl_module.sv */
`timescale 1ns/1ps

module dbg_ctrl_module (
  input  logic                       tck_i,
  input  logic                       tlr_i,
  input  logic                       tdi_i,
  input  logic                       shift_dr_i,
  input  logic                       capture_dr_i,
  input  logic                       update_dr_i,
  input  logic [dbg_pkg::DR_LEN-1:0] data_reg_i,
  input  logic                       sel_i,
  input  dbg_pkg::stall_t            cpu_bp_i,
  output logic                       tdo_o,
  output dbg_pkg::stall_t            cpu_stall_o
);

  import dbg_pkg::*;

  // Breakpoints low, stall mask high
  localparam int CAP_W = 2 * $bits(stall_t);

  logic             wr_q;
  stall_t           mask_q;
  stall_t           stall_q;
  logic [CAP_W-1:0] cap_q;

  // Stage the write, apply one cycle later
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      wr_q    <= 1'b0;
      stall_q <= '0;
    end else begin
      wr_q <= update_dr_i && sel_i && !data_reg_i[DR_SEL_BIT] && data_reg_i[DR_WE_BIT];
      if (wr_q) begin
        stall_q <= mask_q;
      end
    end
  end

  always_ff @(posedge tck_i) begin
    if (update_dr_i && sel_i) begin
      mask_q <= data_reg_i[DR_STALL_MSB -: $bits(stall_t)];
    end
  end

  assign cpu_stall_o = stall_q;

  // Capture and shift out
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      cap_q <= '0;
    end else if (capture_dr_i && sel_i) begin
      cap_q <= {stall_q, cpu_bp_i};
    end else if (shift_dr_i && sel_i) begin
      cap_q <= {tdi_i, cap_q[CAP_W-1:1]};
    end
  end

  assign tdo_o = cap_q[0];

endmodule

/* logic/dbg_pkg.sv */
package dbg_pkg;

  ////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////

  // Bus address and data word
  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  // One bit per CPU, stall mask and breakpoint flags
  typedef logic [3:0]  stall_t;

  // Debug module IDs
  typedef enum logic [1:0] {
    MOD_BUS   = 2'd0,
    MOD_CTRL  = 2'd1,
    MOD_RSVD2 = 2'd2,
    MOD_RSVD3 = 2'd3
  } dbg_module_e;

  // Bus command opcodes, code 3 acts as NOP
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2
  } bus_op_e;

  // Single bus request, 49 bits
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } bus_req_t;

  // Bus master FSM
  typedef enum logic {
    ST_IDLE,
    ST_ACCESS
  } mst_state_e;

  ////////////////////////////////////////
  // Main data register layout
  ////////////////////////////////////////

  localparam int DR_LEN       = 51;
  // Top bit, last one shifted in
  localparam int DR_SEL_BIT   = 50;
  // Module ID on select commands
  localparam int DR_ID_MSB    = 49;
  // Bus commands
  localparam int DR_OP_MSB    = 49;
  localparam int DR_ADDR_MSB  = 47;
  localparam int DR_WDATA_MSB = 31;
  // Control commands
  localparam int DR_WE_BIT    = 49;
  localparam int DR_STALL_MSB = 48;

endpackage

/* logic/dbg_req_fifo.sv */
`timescale 1ns/1ps

module dbg_req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              tck_i,
  input  logic              tlr_i,
  input  logic              push_i,
  input  dbg_pkg::bus_req_t push_data_i,
  input  logic              pop_i,
  output dbg_pkg::bus_req_t head_o,
  output logic              not_empty_o
);

  import dbg_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  // Last slot index, wrap point for any depth
  localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

  bus_req_t         mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Storage
  always_ff @(posedge tck_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign head_o      = mem_q[rd_ptr_q];
  assign not_empty_o = (count_q != '0);

endmodule

/* logic/dbg_top.sv */
`timescale 1ns/1ps

module dbg_top #(
  parameter int FIFO_DEPTH = 4
) (
  // JTAG clock and TAP reset
  input  logic              tck_i,
  input  logic              tlr_i,
  input  logic              tdi_i,
  // TAP state strobes
  input  logic              shift_dr_i,
  input  logic              capture_dr_i,
  input  logic              update_dr_i,
  input  logic              debug_select_i,
  output logic              tdo_o,
  // Memory bus master port
  output dbg_pkg::bus_req_t bus_req_o,
  output logic              bus_valid_o,
  input  logic              bus_ready_i,
  input  dbg_pkg::data_t    bus_rdata_i,
  // CPU debug lines
  input  dbg_pkg::stall_t   cpu_bp_i,
  output dbg_pkg::stall_t   cpu_stall_o
);

  import dbg_pkg::*;

  // Shared data register and selects
  logic [DR_LEN-1:0] data_reg;
  logic              bus_sel;
  logic              ctrl_sel;
  // Per-module TDO and inhibit
  logic              bus_tdo;
  logic              ctrl_tdo;
  logic              bus_inhibit;
  // Bus module to FIFO
  logic              push;
  bus_req_t          push_req;
  // FIFO to master
  logic              not_empty;
  bus_req_t          head;
  logic              pop;
  // Master back to bus module
  logic              busy;
  logic              rsp_valid;
  data_t             rsp_data;

  ////////////////////////////////////////
  // Chain front end
  ////////////////////////////////////////

  dbg_chain_select u_chain_select (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .data_reg_o     (data_reg),
    .bus_sel_o      (bus_sel),
    .ctrl_sel_o     (ctrl_sel),
    .bus_inhibit_i  (bus_inhibit),
    .bus_tdo_i      (bus_tdo),
    .ctrl_tdo_i     (ctrl_tdo),
    .tdo_o          (tdo_o)
  );

  ////////////////////////////////////////
  // Bus path
  ////////////////////////////////////////

  dbg_bus_module u_bus_module (
    .tck_i            (tck_i),
    .tlr_i            (tlr_i),
    .tdi_i            (tdi_i),
    .shift_dr_i       (shift_dr_i),
    .capture_dr_i     (capture_dr_i),
    .update_dr_i      (update_dr_i),
    .data_reg_i       (data_reg),
    .sel_i            (bus_sel),
    .tdo_o            (bus_tdo),
    .inhibit_o        (bus_inhibit),
    .push_o           (push),
    .push_req_o       (push_req),
    .fifo_not_empty_i (not_empty),
    .master_busy_i    (busy),
    .rsp_valid_i      (rsp_valid),
    .rsp_data_i       (rsp_data)
  );

  dbg_req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_req_fifo (
    .tck_i       (tck_i),
    .tlr_i       (tlr_i),
    .push_i      (push),
    .push_data_i (push_req),
    .pop_i       (pop),
    .head_o      (head),
    .not_empty_o (not_empty)
  );

  dbg_bus_master u_bus_master (
    .tck_i       (tck_i),
    .tlr_i       (tlr_i),
    .not_empty_i (not_empty),
    .head_i      (head),
    .pop_o       (pop),
    .busy_o      (busy),
    .bus_req_o   (bus_req_o),
    .bus_valid_o (bus_valid_o),
    .bus_ready_i (bus_ready_i),
    .bus_rdata_i (bus_rdata_i),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data)
  );

  // CPU control
  dbg_ctrl_module u_ctrl_module (
    .tck_i        (tck_i),
    .tlr_i        (tlr_i),
    .tdi_i        (tdi_i),
    .shift_dr_i   (shift_dr_i),
    .capture_dr_i (capture_dr_i),
    .update_dr_i  (update_dr_i),
    .data_reg_i   (data_reg),
    .sel_i        (ctrl_sel),
    .cpu_bp_i     (cpu_bp_i),
    .tdo_o        (ctrl_tdo),
    .cpu_stall_o  (cpu_stall_o)
  );

endmodule

/* tb/dbg_tb.sv */
`timescale 1ns/1ps

module dbg_tb;

  import dbg_pkg::*;

  localparam int N_OPS      = 8;
  // Bus commands, control, reserved and inhibit sequences
  localparam int N_CMDS     = 2 * N_OPS + 8;
  localparam int WD_CYCLES  = N_CMDS * (DR_LEN + 60) + 2000;
  localparam int IDLE_LIMIT = 200;
  localparam int SEED       = 32'h6170;

  // DUT inputs
  logic     tck_i = 1'b0;
  logic     tlr_i;
  logic     tdi_i;
  logic     shift_dr_i;
  logic     capture_dr_i;
  logic     update_dr_i;
  logic     debug_select_i;
  logic     bus_ready_i;
  data_t    bus_rdata_i;
  stall_t   cpu_bp_i;
  // DUT outputs
  logic     tdo_o;
  bus_req_t bus_req_o;
  logic     bus_valid_o;
  stall_t   cpu_stall_o;

  // Error bookkeeping
  int       errors = 0;
  int       checks = 0;
  integer   seed;
  integer   wait_seed;

  // Memory model state
  data_t    ref_mem [64];
  bus_req_t exp_q [$];
  bus_req_t acc_req;
  logic     acc_active = 1'b0;
  logic     hold_ready = 1'b0;
  int       wait_left;

  dbg_top #(
    .FIFO_DEPTH (4)
  ) DUT (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .capture_dr_i   (capture_dr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .tdo_o          (tdo_o),
    .bus_req_o      (bus_req_o),
    .bus_valid_o    (bus_valid_o),
    .bus_ready_i    (bus_ready_i),
    .bus_rdata_i    (bus_rdata_i),
    .cpu_bp_i       (cpu_bp_i),
    .cpu_stall_o    (cpu_stall_o)
  );

  // 4 ns TCK
  always #2 tck_i = ~tck_i;

  ////////////////////////////////////////
  // Checks and command encoding
  ////////////////////////////////////////

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Top bit set and ID in 49..48
  // Ones in the unused bits leave each module's TDO high
  function automatic logic [DR_LEN-1:0] select_command(input logic [1:0] id);
    logic [DR_LEN-1:0] v;
    v        = '1;
    v[50]    = 1'b1;
    v[49:48] = id;
    return v;
  endfunction

  function automatic logic [DR_LEN-1:0] bus_command(input logic [1:0] op, input addr_t addr,
                                                    input data_t data);
    logic [DR_LEN-1:0] v;
    v        = '0;
    v[49:48] = op;
    v[47:32] = addr;
    v[31:0]  = data;
    return v;
  endfunction

  // Write enable in 49 and mask in 48..45
  function automatic logic [DR_LEN-1:0] ctrl_command(input logic we, input stall_t mask);
    logic [DR_LEN-1:0] v;
    v        = '0;
    v[49]    = we;
    v[48:45] = mask;
    return v;
  endfunction

  ////////////////////////////////////////
  // JTAG driver tasks
  ////////////////////////////////////////

  // LSB first and then one Update-DR cycle
  task automatic load_command(input logic [DR_LEN-1:0] value);
    int i;
    for (i = 0; i < DR_LEN; i++) begin
      @(posedge tck_i);
      #1;
      shift_dr_i = 1'b1;
      tdi_i      = value[i];
    end
    @(posedge tck_i);
    #1;
    shift_dr_i  = 1'b0;
    update_dr_i = 1'b1;
    @(posedge tck_i);
    #1;
    update_dr_i = 1'b0;
  endtask

  // Capture-DR and then n bits of TDO
  task automatic capture_and_shift(input int n, output logic [63:0] bits);
    int i;
    bits = '0;
    @(posedge tck_i);
    #1;
    capture_dr_i = 1'b1;
    @(posedge tck_i);
    #1;
    capture_dr_i = 1'b0;
    shift_dr_i   = 1'b1;
    tdi_i        = $random(seed);
    bits[0]      = tdo_o;
    for (i = 1; i < n; i++) begin
      @(posedge tck_i);
      #1;
      tdi_i   = $random(seed);
      bits[i] = tdo_o;
    end
    shift_dr_i = 1'b0;
  endtask

  // All expected accesses seen and bus quiet
  task automatic wait_bus_idle();
    int cycles;
    cycles = 0;
    do begin
      @(posedge tck_i);
      #1;
      cycles++;
    end while (!(exp_q.size() == 0 && !bus_valid_o) && cycles < IDLE_LIMIT);
    assert (cycles < IDLE_LIMIT) else begin
      errors++;
      $display("Bus did not return to idle within %0d cycles", IDLE_LIMIT);
    end
    // Response strobe and rd_valid settle
    repeat (2) begin
      @(posedge tck_i);
      #1;
    end
  endtask

  task automatic wait_bus_valid();
    int cycles;
    cycles = 0;
    while (!bus_valid_o && cycles < IDLE_LIMIT) begin
      @(posedge tck_i);
      #1;
      cycles++;
    end
    assert (bus_valid_o) else begin
      errors++;
      $display("Bus access never started after the write command");
    end
  endtask

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  // Decodes addr[5:0] with 0 to 5 wait cycles
  always begin : memory_model
    bus_req_t exp;
    @(posedge tck_i);
    #1;
    if (acc_active && bus_ready_i) begin
      // Completing edge just passed
      if (acc_req.write) begin
        ref_mem[acc_req.addr[5:0]] = acc_req.data;
      end
      acc_active  = 1'b0;
      bus_ready_i = 1'b0;
    end
    if (bus_valid_o && !acc_active) begin
      acc_active = 1'b1;
      acc_req    = bus_req_o;
      wait_left  = $unsigned($random(wait_seed)) % 6;
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("Unexpected bus access to address 0x%0h", bus_req_o.addr);
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        check_equal("bus_req_o.write", bus_req_o.write, exp.write);
        check_equal("bus_req_o.addr", bus_req_o.addr, exp.addr);
        if (exp.write) begin
          check_equal("bus_req_o.data", bus_req_o.data, exp.data);
        end
      end
      bus_rdata_i = bus_req_o.write ? data_t'($random(wait_seed)) : ref_mem[bus_req_o.addr[5:0]];
    end else if (acc_active) begin
      // Request must stay put while waiting
      check_equal("bus_req_o", bus_req_o, acc_req);
    end
    if (acc_active && !bus_ready_i && !hold_ready) begin
      if (wait_left == 0) begin
        bus_ready_i = 1'b1;
      end else begin
        wait_left--;
      end
    end
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge tck_i);
    $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    addr_t        wr_addr [N_OPS];
    addr_t        addr;
    data_t        wdata;
    stall_t       mask;
    stall_t       bp;
    bus_req_t     req;
    logic [63:0]  bits;
    int           i;

    seed      = SEED;
    wait_seed = SEED;
    // Fill pattern over the whole index
    for (i = 0; i < 64; i++) begin
      ref_mem[i] = 32'h5A00_0000 ^ (i * 32'h0003_0507);
    end
    tlr_i          = 1'b1;
    tdi_i          = 1'b0;
    shift_dr_i     = 1'b0;
    capture_dr_i   = 1'b0;
    update_dr_i    = 1'b0;
    debug_select_i = 1'b0;
    bus_ready_i    = 1'b0;
    bus_rdata_i    = '0;
    cpu_bp_i       = '0;

    repeat (3) @(posedge tck_i);
    #1;
    tlr_i          = 1'b0;
    debug_select_i = 1'b1;

    // Reset state
    check_equal("bus_valid_o", bus_valid_o, 1'b0);
    check_equal("cpu_stall_o", cpu_stall_o, 4'h0);
    check_equal("tdo_o", tdo_o, 1'b0);

    // Back-to-back writes in order on the bus
    for (i = 0; i < N_OPS; i++) begin
      wr_addr[i] = $random(seed);
      wdata      = $random(seed);
      req.write  = 1'b1;
      req.addr   = wr_addr[i];
      req.data   = wdata;
      exp_q.push_back(req);
      load_command(bus_command(2'd1, wr_addr[i], wdata));
    end
    wait_bus_idle();

    // Half of the reads hit written words
    for (i = 0; i < N_OPS; i++) begin
      addr      = (i % 2 == 0) ? wr_addr[i] : addr_t'($random(seed));
      req.write = 1'b0;
      req.addr  = addr;
      req.data  = '0;
      exp_q.push_back(req);
      load_command(bus_command(2'd2, addr, data_t'($random(seed))));
      wait_bus_idle();
      capture_and_shift(33, bits);
      check_equal("rd_valid", bits[0], 1'b1);
      check_equal("rdata", bits[32:1], ref_mem[addr[5:0]]);
    end

    // Control module stall mask and breakpoints
    load_command(select_command(2'd1));
    mask = $random(seed);
    load_command(ctrl_command(1'b1, mask));
    @(posedge tck_i);
    #1;
    check_equal("cpu_stall_o", cpu_stall_o, mask);
    bp       = $random(seed);
    cpu_bp_i = bp;
    capture_and_shift(8, bits);
    check_equal("ctrl cpu_bp", bits[3:0], bp);
    check_equal("ctrl stall mask", bits[7:4], mask);

    // Reserved IDs keep TDO low
    load_command(select_command(2'd2));
    capture_and_shift(DR_LEN, bits);
    check_equal("tdo_o bits (ID 2)", bits, 64'h0);
    load_command(select_command(2'd3));
    capture_and_shift(DR_LEN, bits);
    check_equal("tdo_o bits (ID 3)", bits, 64'h0);

    // Select ignored while a write is stuck on the bus
    load_command(select_command(2'd0));
    hold_ready = 1'b1;
    addr       = $random(seed);
    wdata      = $random(seed);
    req.write  = 1'b1;
    req.addr   = addr;
    req.data   = wdata;
    exp_q.push_back(req);
    load_command(bus_command(2'd1, addr, wdata));
    wait_bus_valid();
    load_command(select_command(2'd1));
    check_equal("bus_valid_o", bus_valid_o, 1'b1);
    hold_ready = 1'b0;
    wait_bus_idle();
    req.write = 1'b0;
    req.data  = '0;
    exp_q.push_back(req);
    load_command(bus_command(2'd2, addr, '0));
    wait_bus_idle();
    capture_and_shift(33, bits);
    check_equal("rd_valid", bits[0], 1'b1);
    check_equal("rdata", bits[32:1], wdata);

    repeat (10) @(posedge tck_i);
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d expected bus accesses never appeared", exp_q.size());
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
